// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cp0_subsystem
RTL_TOP   ?= cp0_subsystem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+include
hw/cp0_pkg.sv
hw/exc_report_if.sv
hw/cp0.sv
hw/exc_arbiter.sv
hw/cp0_subsystem.sv
test/tb_cp0_subsystem.sv

// File: hw/cp0.sv
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0 (
    input  logic                           clk,
    input  logic                           reset,
    input  cp0_pkg::cp0_write_t [1:0]      cwrite,
    input  cp0_pkg::creg_addr_t [1:0]      ra,
    output cp0_pkg::word_t [1:0]           rd,
    exc_report_if.sink                     report,
    input  logic                           is_eret,
    input  cp0_pkg::hw_int_t               hw_int,
    output logic                           timer_interrupt,
    output cp0_pkg::cp0_status_t           cp0_status,
    output cp0_pkg::cp0_cause_t            cp0_cause,
    output cp0_pkg::word_t                 cp0_epc
);

    cp0_pkg::cp0_regs_t regs;
    cp0_pkg::cp0_regs_t regs_next;
    logic               count_toggle;
    logic               compare_wr;

    always_ff @(posedge clk) begin
        if (!reset) begin
            regs <= `CP0_INIT;
        end else begin
            regs <= regs_next;
        end
    end

    // count runs at half the core clock
    always_ff @(posedge clk) begin
        if (!reset) begin
            count_toggle <= 1'b1;
        end else begin
            count_toggle <= ~count_toggle;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            case (ra[i])
                `CP0_BADVADDR: rd[i] = regs.badvaddr;
                `CP0_COUNT:    rd[i] = regs.count;
                `CP0_COMPARE:  rd[i] = regs.compare;
                `CP0_STATUS:   rd[i] = regs.status;
                `CP0_CAUSE:    rd[i] = regs.cause;
                `CP0_EPC:      rd[i] = regs.epc;
                `CP0_CONFIG:   rd[i] = regs.config_;
                default:       rd[i] = '0;
            endcase
        end
    end

    always_comb begin
        compare_wr = (cwrite[1].wen && cwrite[1].addr == `CP0_COMPARE) ||
                     (cwrite[0].wen && cwrite[0].addr == `CP0_COMPARE);
    end

    // set on the update that reaches compare - 1, held until compare is rewritten
    always_ff @(posedge clk) begin
        if (!reset) begin
            timer_interrupt <= 1'b0;
        end else if (regs_next.count == regs_next.compare - 32'd1) begin
            timer_interrupt <= 1'b1;
        end else if (compare_wr) begin
            timer_interrupt <= 1'b0;
        end
    end

    always_comb begin
        regs_next = regs;
        regs_next.count = regs.count + {31'b0, count_toggle};

        // hardware lines sampled every cycle
        regs_next.cause.IP[7:2] = {timer_interrupt | hw_int[5], hw_int[4:0]};
        regs_next.cause.TI      = timer_interrupt;

        // slot 1 first so that slot 0 wins on the same register
        for (int i = 1; i >= 0; i--) begin
            if (cwrite[i].wen) begin
                case (cwrite[i].addr)
                    `CP0_COUNT:   regs_next.count = cwrite[i].wd;
                    `CP0_COMPARE: regs_next.compare = cwrite[i].wd;
                    `CP0_STATUS: begin
                        regs_next.status.IM  = cwrite[i].wd[15:8];
                        regs_next.status.EXL = cwrite[i].wd[1];
                        regs_next.status.IE  = cwrite[i].wd[0];
                    end
                    `CP0_CAUSE:   regs_next.cause.IP[1:0] = cwrite[i].wd[9:8];
                    `CP0_EPC:     regs_next.epc = cwrite[i].wd;
                    default: ;
                endcase
            end
        end

        if (report.valid) begin
            // nested exception keeps the first epc
            if (!regs.status.EXL) begin
                regs_next.cause.BD = report.in_delay_slot;
                regs_next.epc = report.in_delay_slot ? report.pc - 32'd4 : report.pc;
            end
            regs_next.cause.exccode = report.code;
            regs_next.status.EXL    = 1'b1;
            if (report.code == `CODE_ADEL || report.code == `CODE_ADES) begin
                regs_next.badvaddr = report.badvaddr;
            end
        end

        if (is_eret) begin
            if (regs.status.ERL) begin
                regs_next.status.ERL = 1'b0;
            end else begin
                regs_next.status.EXL = 1'b0;
            end
        end
    end

    assign cp0_status = regs.status;
    assign cp0_cause  = regs.cause;
    assign cp0_epc    = regs.epc;

    // only IM, ERL, EXL and IE may ever leave their reset value
    a_status_ro: assert property (@(posedge clk) disable iff (!reset)
        (regs.status & ~`STATUS_RW_MASK) == (`STATUS_RESET & ~`STATUS_RW_MASK))
        else $error("status read-only bits changed: %h", regs.status);

    a_badvaddr_src: assert property (@(posedge clk) disable iff (!reset)
        !(report.valid && (report.code == `CODE_ADEL || report.code == `CODE_ADES))
        |=> $stable(regs.badvaddr))
        else $error("badvaddr changed without address error: %h", regs.badvaddr);

endmodule

// File: hw/cp0_pkg.sv
package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [4:0]  exccode_t;
    typedef logic [5:0]  hw_int_t;

    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } cp0_write_t;

    typedef struct packed {
        logic [8:0] zero31_23;
        logic       BEV;
        logic [5:0] zero21_16;
        logic [7:0] IM;
        logic [4:0] zero7_3;
        logic       ERL;
        logic       EXL;
        logic       IE;
    } cp0_status_t;

    typedef struct packed {
        logic        BD;
        logic        TI;
        logic [13:0] zero29_16;
        logic [7:0]  IP;
        logic        zero7;
        exccode_t    exccode;
        logic [1:0]  zero1_0;
    } cp0_cause_t;

    typedef struct packed {
        word_t       badvaddr;
        word_t       count;
        word_t       compare;
        cp0_status_t status;
        cp0_cause_t  cause;
        word_t       epc;
        word_t       config_;
    } cp0_regs_t;

    // one retiring instruction
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        logic       in_delay_slot;
        logic       exc_valid;
        exccode_t   exc_code;
        addr_t      badvaddr;
        cp0_write_t cwrite;
        logic       is_eret;
    } commit_t;

    typedef enum logic [1:0] {
        ARB_NONE,
        ARB_EXCEPTION,
        ARB_INTERRUPT,
        ARB_ERET
    } arb_kind_t;

endpackage

// File: hw/cp0_subsystem.sv
`timescale 1ns/1ps

module cp0_subsystem (
    input  logic                         clk,
    input  logic                         reset,
    input  cp0_pkg::commit_t [1:0]       commit,
    input  cp0_pkg::creg_addr_t [1:0]    ra,
    output cp0_pkg::word_t [1:0]         rd,
    input  cp0_pkg::hw_int_t             hw_int,
    output logic                         redirect_valid,
    output cp0_pkg::addr_t               redirect_pc,
    output logic                         timer_interrupt
);

    cp0_pkg::cp0_write_t [1:0] cwrite;
    logic                      is_eret;
    cp0_pkg::cp0_status_t      cp0_status;
    cp0_pkg::cp0_cause_t       cp0_cause;
    cp0_pkg::word_t            cp0_epc;

    exc_report_if report_bus ();

    exc_arbiter u_exc_arbiter (
        .commit         (commit),
        .cp0_status     (cp0_status),
        .cp0_cause      (cp0_cause),
        .cp0_epc        (cp0_epc),
        .report         (report_bus.source),
        .cwrite         (cwrite),
        .is_eret        (is_eret),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    cp0 u_cp0 (
        .clk             (clk),
        .reset           (reset),
        .cwrite          (cwrite),
        .ra              (ra),
        .rd              (rd),
        .report          (report_bus.sink),
        .is_eret         (is_eret),
        .hw_int          (hw_int),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (cp0_status),
        .cp0_cause       (cp0_cause),
        .cp0_epc         (cp0_epc)
    );

endmodule

// File: hw/exc_arbiter.sv
`timescale 1ns/1ps
`include "cp0_macros.svh"

module exc_arbiter (
    input  cp0_pkg::commit_t [1:0]       commit,
    input  cp0_pkg::cp0_status_t         cp0_status,
    input  cp0_pkg::cp0_cause_t          cp0_cause,
    input  cp0_pkg::word_t               cp0_epc,
    exc_report_if.source                 report,
    output cp0_pkg::cp0_write_t [1:0]    cwrite,
    output logic                         is_eret,
    output logic                         redirect_valid,
    output cp0_pkg::addr_t               redirect_pc
);

    cp0_pkg::arb_kind_t kind;
    logic               sel;
    logic               int_pending;
    logic [1:0]         keep;

    assign int_pending = cp0_status.IE && !cp0_status.EXL && !cp0_status.ERL &&
                         (|(cp0_status.IM & cp0_cause.IP)) &&
                         (commit[1].valid || commit[0].valid);

    // slot 1 is the older instruction
    always_comb begin
        kind = cp0_pkg::ARB_NONE;
        sel  = 1'b1;
        if (int_pending) begin
            kind = cp0_pkg::ARB_INTERRUPT;
            sel  = commit[1].valid;
        end else if (commit[1].valid && commit[1].exc_valid) begin
            kind = cp0_pkg::ARB_EXCEPTION;
            sel  = 1'b1;
        end else if (commit[0].valid && commit[0].exc_valid) begin
            kind = cp0_pkg::ARB_EXCEPTION;
            sel  = 1'b0;
        end else if (commit[1].valid && commit[1].is_eret) begin
            kind = cp0_pkg::ARB_ERET;
            sel  = 1'b1;
        end else if (commit[0].valid && commit[0].is_eret) begin
            kind = cp0_pkg::ARB_ERET;
            sel  = 1'b0;
        end
    end

    // the selected slot and everything younger are killed, eret itself retires
    always_comb begin
        keep[1] = commit[1].valid &&
                  (kind == cp0_pkg::ARB_NONE || kind == cp0_pkg::ARB_ERET || !sel);
        keep[0] = commit[0].valid &&
                  (kind == cp0_pkg::ARB_NONE || (kind == cp0_pkg::ARB_ERET && !sel));
        for (int i = 0; i < 2; i++) begin
            cwrite[i]     = commit[i].cwrite;
            cwrite[i].wen = commit[i].cwrite.wen && keep[i];
        end
    end

    always_comb begin
        report.valid         = kind == cp0_pkg::ARB_EXCEPTION ||
                               kind == cp0_pkg::ARB_INTERRUPT;
        report.code          = (kind == cp0_pkg::ARB_INTERRUPT) ? `CODE_INT
                                                                : commit[sel].exc_code;
        report.pc            = commit[sel].pc;
        report.in_delay_slot = commit[sel].in_delay_slot;
        report.badvaddr      = commit[sel].badvaddr;
    end

    assign is_eret        = kind == cp0_pkg::ARB_ERET;
    assign redirect_valid = kind != cp0_pkg::ARB_NONE;
    assign redirect_pc    = is_eret ? cp0_epc : `EXC_VECTOR;

    // cp0 would apply both updates in the same cycle
    always_comb begin
        a_report_eret: assert (!(report.valid && is_eret))
            else $error("exception report and eret in the same cycle");
    end

endmodule

// File: hw/exc_report_if.sv
`timescale 1ns/1ps

interface exc_report_if;

    logic               valid;
    cp0_pkg::exccode_t  code;
    cp0_pkg::addr_t     pc;
    logic               in_delay_slot;
    cp0_pkg::addr_t     badvaddr;

    modport source (
        output valid, code, pc, in_delay_slot, badvaddr
    );

    modport sink (
        input valid, code, pc, in_delay_slot, badvaddr
    );

endinterface

// File: include/cp0_macros.svh
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// cp0 register numbers
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_CONFIG      5'd16

// cause.exccode values
`define CODE_INT        5'd0
`define CODE_ADEL       5'd4
`define CODE_ADES       5'd5
`define CODE_SYS        5'd8
`define CODE_BP         5'd9
`define CODE_RI         5'd10
`define CODE_OV         5'd12

// general exception entry with BEV set
`define EXC_VECTOR      32'hBFC0_0380

// M bit only, no optional config registers
`define CONFIG_VALUE    32'h8000_0000

// BEV and ERL set out of reset
`define STATUS_RESET    32'h0040_0004
// IM, ERL, EXL, IE
`define STATUS_RW_MASK  32'h0000_FF07

`define CP0_INIT '{badvaddr: 32'h0, count: 32'h0, compare: 32'h0, \
                   status: `STATUS_RESET, cause: 32'h0, epc: 32'h0, \
                   config_: `CONFIG_VALUE}

`endif

// File: test/tb_cp0_subsystem.sv
`timescale 1ns/1ps
`include "cp0_macros.svh"

module tb_cp0_subsystem;

    localparam int CLK_PERIOD  = 100;
    // rough sum of the test lengths in cycles
    localparam int TEST_CYCLES = 400;

    // bev and erl only
    localparam cp0_pkg::word_t   STATUS_RESET_EXP = 32'h0040_0004;
    // im, exl, ie
    localparam cp0_pkg::word_t   STATUS_WR_MASK   = 32'h0000_FF03;
    localparam cp0_pkg::commit_t IDLE             = '0;

    logic                      clk;
    logic                      reset;
    cp0_pkg::commit_t [1:0]    commit;
    cp0_pkg::creg_addr_t [1:0] ra;
    cp0_pkg::word_t [1:0]      rd;
    cp0_pkg::hw_int_t          hw_int;
    logic                      redirect_valid;
    cp0_pkg::addr_t            redirect_pc;
    logic                      timer_interrupt;

    int             errors;
    int             checks;
    logic           seen_redirect;
    cp0_pkg::addr_t seen_pc;
    cp0_pkg::word_t exp_epc;

    cp0_subsystem u_dut (
        .clk             (clk),
        .reset           (reset),
        .commit          (commit),
        .ra              (ra),
        .rd              (rd),
        .hw_int          (hw_int),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .timer_interrupt (timer_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic expect_word(input string name, input cp0_pkg::word_t got,
                               input cp0_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // one commit pair for one cycle, redirect sampled mid-cycle
    task automatic issue(input cp0_pkg::commit_t older, input cp0_pkg::commit_t younger);
        commit[1] = older;
        commit[0] = younger;
        #40;
        seen_redirect = redirect_valid;
        seen_pc       = redirect_pc;
        next_cycle();
        commit = '0;
    endtask

    task automatic expect_redirect(input cp0_pkg::addr_t pc);
        expect_word("redirect_valid", {31'b0, seen_redirect}, 32'h1);
        expect_word("redirect_pc", seen_pc, pc);
    endtask

    task automatic check_reg(input string name, input cp0_pkg::creg_addr_t addr,
                             input cp0_pkg::word_t mask, input cp0_pkg::word_t exp);
        cp0_pkg::word_t value;
        ra[0] = addr;
        #40;
        value = rd[0];
        next_cycle();
        expect_word(name, value & mask, exp);
    endtask

    function automatic cp0_pkg::commit_t write_rec(input cp0_pkg::creg_addr_t addr,
                                                   input cp0_pkg::word_t wd);
        cp0_pkg::commit_t c;
        c             = '0;
        c.valid       = 1'b1;
        c.pc          = 32'h8000_1000;
        c.cwrite.wen  = 1'b1;
        c.cwrite.addr = addr;
        c.cwrite.wd   = wd;
        return c;
    endfunction

    function automatic cp0_pkg::commit_t exc_rec(input cp0_pkg::exccode_t code,
                                                 input cp0_pkg::addr_t pc, input logic in_ds,
                                                 input cp0_pkg::addr_t bva);
        cp0_pkg::commit_t c;
        c               = '0;
        c.valid         = 1'b1;
        c.pc            = pc;
        c.in_delay_slot = in_ds;
        c.exc_valid     = 1'b1;
        c.exc_code      = code;
        c.badvaddr      = bva;
        return c;
    endfunction

    task automatic check_reset_state();
        int             i;
        cp0_pkg::word_t exp;
        for (i = 0; i < 32; i++) begin
            case (i[4:0])
                `CP0_STATUS: exp = STATUS_RESET_EXP;
                `CP0_CONFIG: exp = `CONFIG_VALUE;
                default:     exp = '0;
            endcase
            ra[0] = i[4:0];
            ra[1] = i[4:0];
            #1;
            expect_word($sformatf("rd[0] reg %0d", i), rd[0], exp);
            expect_word($sformatf("rd[1] reg %0d", i), rd[1], exp);
        end
        expect_word("redirect_valid", {31'b0, redirect_valid}, 32'h0);
        expect_word("timer_interrupt", {31'b0, timer_interrupt}, 32'h0);
        next_cycle();
    endtask

    task automatic write_and_mask();
        cp0_pkg::word_t   epc_v;
        cp0_pkg::word_t   cmp_v;
        cp0_pkg::word_t   st_v;
        cp0_pkg::commit_t dead;
        epc_v = $urandom;
        // top bit keeps compare far from count
        cmp_v = $urandom | 32'h8000_0000;
        st_v  = $urandom;
        issue(write_rec(`CP0_EPC, epc_v), write_rec(`CP0_COMPARE, cmp_v));
        issue(IDLE, write_rec(`CP0_STATUS, st_v));
        check_reg("epc", `CP0_EPC, '1, epc_v);
        check_reg("compare", `CP0_COMPARE, '1, cmp_v);
        check_reg("status", `CP0_STATUS, '1, STATUS_RESET_EXP | (st_v & STATUS_WR_MASK));
        issue(IDLE, write_rec(`CP0_STATUS, 32'h0));
        check_reg("status", `CP0_STATUS, '1, STATUS_RESET_EXP);
        epc_v = $urandom;
        issue(write_rec(`CP0_EPC, ~epc_v), write_rec(`CP0_EPC, epc_v));
        check_reg("epc", `CP0_EPC, '1, epc_v);
        dead       = write_rec(`CP0_EPC, ~epc_v);
        dead.valid = 1'b0;
        issue(IDLE, dead);
        check_reg("epc", `CP0_EPC, '1, epc_v);
    endtask

    task automatic take_exceptions();
        cp0_pkg::addr_t pc_v;
        pc_v = 32'h8000_2000 | ($urandom & 32'h0000_0FFC);
        issue(exc_rec(`CODE_SYS, pc_v, 1'b1, 32'h0), write_rec(`CP0_EPC, $urandom));
        expect_redirect(`EXC_VECTOR);
        exp_epc = pc_v - 32'd4;
        check_reg("epc", `CP0_EPC, '1, exp_epc);
        check_reg("cause.bd/exccode", `CP0_CAUSE, 32'h8000_007C,
                  {1'b1, 24'b0, `CODE_SYS, 2'b0});
        check_reg("status.exl", `CP0_STATUS, 32'h2, 32'h2);
        // nested exception keeps epc and kills the younger write
        issue(exc_rec(`CODE_RI, pc_v + 32'h40, 1'b0, 32'h0), write_rec(`CP0_EPC, ~exp_epc));
        expect_redirect(`EXC_VECTOR);
        check_reg("epc", `CP0_EPC, '1, exp_epc);
        check_reg("cause.exccode", `CP0_CAUSE, 32'h7C, {25'b0, `CODE_RI, 2'b0});
    endtask

    task automatic address_errors();
        cp0_pkg::addr_t bva;
        bva = $urandom;
        issue(IDLE, exc_rec(`CODE_ADEL, 32'h8000_3000, 1'b0, bva));
        check_reg("badvaddr", `CP0_BADVADDR, '1, bva);
        bva = $urandom;
        issue(exc_rec(`CODE_ADES, 32'h8000_3004, 1'b0, bva), IDLE);
        check_reg("badvaddr", `CP0_BADVADDR, '1, bva);
        issue(exc_rec(`CODE_OV, 32'h8000_3008, 1'b0, ~bva), IDLE);
        check_reg("badvaddr", `CP0_BADVADDR, '1, bva);
        check_reg("cause.exccode", `CP0_CAUSE, 32'h7C, {25'b0, `CODE_OV, 2'b0});
    endtask

    task automatic return_from_exception();
        cp0_pkg::commit_t eret;
        eret         = IDLE;
        eret.valid   = 1'b1;
        eret.pc      = 32'h8000_4000;
        eret.is_eret = 1'b1;
        check_reg("status.erl/exl", `CP0_STATUS, 32'h6, 32'h6);
        check_reg("epc", `CP0_EPC, '1, exp_epc);
        issue(eret, IDLE);
        expect_redirect(exp_epc);
        check_reg("status.erl/exl", `CP0_STATUS, 32'h6, 32'h2);
        exp_epc = $urandom & 32'hFFFF_FFFC;
        issue(IDLE, write_rec(`CP0_EPC, exp_epc));
        check_reg("epc", `CP0_EPC, '1, exp_epc);
        // younger epc write dies with the eret
        issue(eret, write_rec(`CP0_EPC, ~exp_epc));
        expect_redirect(exp_epc);
        check_reg("status.erl/exl", `CP0_STATUS, 32'h6, 32'h0);
        check_reg("epc", `CP0_EPC, '1, exp_epc);
    endtask

    task automatic interrupts_and_timer();
        cp0_pkg::word_t n;
        int             waited;
        // ie plus im[4], fed by hw_int[2]
        issue(IDLE, write_rec(`CP0_STATUS, 32'h0000_1001));
        hw_int = 6'b000100;
        next_cycle();
        issue(write_rec(`CP0_EPC, 32'h1234_5678), IDLE);
        expect_redirect(`EXC_VECTOR);
        check_reg("cause.ip4/exccode", `CP0_CAUSE, 32'h0000_107C, 32'h0000_1000);
        hw_int = '0;
        check_reg("epc", `CP0_EPC, '1, 32'h8000_1000);
        check_reg("status.exl", `CP0_STATUS, 32'h2, 32'h2);

        n = $urandom & 32'h7FFF_FFF0;
        issue(write_rec(`CP0_COUNT, n), write_rec(`CP0_COMPARE, n + 32'd8));
        ra[1]  = `CP0_COUNT;
        waited = 0;
        while (!timer_interrupt && waited < 20) begin
            next_cycle();
            waited++;
        end
        checks++;
        if (!timer_interrupt) begin
            $display("timer interrupt did not rise within 20 cycles of the compare write");
            errors++;
        end else begin
            // one below compare when it rises
            expect_word("count", rd[1], n + 32'd7);
        end
        issue(IDLE, write_rec(`CP0_COMPARE, n + 32'h1000));
        expect_word("timer_interrupt", {31'b0, timer_interrupt}, 32'h0);
    endtask

    initial begin
        void'($urandom(22));
        errors = 0;
        checks = 0;
        reset  = 1'b0;
        commit = '0;
        ra     = '0;
        hw_int = '0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b1;
        check_reset_state();
        write_and_mask();
        take_exceptions();
        address_errors();
        return_from_exception();
        interrupts_and_timer();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES * 2);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
